/* Makefile */
VERILATOR := verilator
TOP       := tb_serial_loader
FILELIST  := build.f
VFLAGS    := --binary --timing --timescale 1ns/1ps --top-module $(TOP)
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+logic
logic/loader_pkg.sv
logic/byte_stream_if.sv
logic/record_if.sv
logic/uart_rx.sv
logic/record_packer.sv
logic/mem_writer.sv
logic/prog_mem.sv
logic/uart_tx.sv
logic/serial_loader_top.sv
verif/tb_serial_loader.sv

/* logic/byte_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One received byte from the UART to the record packer
interface byte_stream_if;
   import loader_pkg::*;

   logic  valid;
   logic  ready;
   byte_t data;
   logic  frame_err;

   modport src (output valid, output data, output frame_err, input ready);
   modport dst (input valid, input data, input frame_err, output ready);

endinterface

`default_nettype wire

/* logic/loader_params.svh */
`ifndef LOADER_PARAMS_SVH
`define LOADER_PARAMS_SVH

// Program memory size in 64-bit words
`define LOADER_MEM_DEPTH 16384

// Bytes per host record: two address bytes then eight data bytes
`define LOADER_REC_BYTES 10

// Negative acknowledge returned for a record with a framing error
`define LOADER_NAK 8'h15

// Clock cycles per bit at 100 MHz
`define LOADER_DIV_9600   14'd10417
`define LOADER_DIV_19200  14'd5208
`define LOADER_DIV_57600  14'd1736
`define LOADER_DIV_115200 14'd868

`endif

/* logic/loader_pkg.sv */
`default_nettype none

`include "loader_params.svh"

package loader_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [13:0] mem_addr_t;
   typedef logic [63:0] mem_word_t;
   typedef logic [1:0]  baud_cfg_t;
   typedef logic [13:0] bit_div_t;

   // Packer: gather bytes, then offer the record downstream
   typedef enum logic {
      COLLECT,
      HOLD
   } pack_state_t;

   // Baud selection as on the board DIP switches
   function automatic bit_div_t baud_divisor(input baud_cfg_t cfg);
      bit_div_t div;
      case (cfg)
         2'b00:   div = `LOADER_DIV_9600;
         2'b01:   div = `LOADER_DIV_19200;
         2'b10:   div = `LOADER_DIV_57600;
         default: div = `LOADER_DIV_115200;
      endcase
      return div;
   endfunction

endpackage

`default_nettype wire

/* logic/mem_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module mem_writer (
   input  logic                  clk_100mhz_buf,
   input  logic                  rst_n,
   record_if.dst                 in,
   output logic                  wr_en,
   output loader_pkg::mem_addr_t wr_addr,
   output loader_pkg::mem_word_t wr_data,
   output logic                  ack_valid,
   input  logic                  ack_ready,
   output loader_pkg::byte_t     ack_byte
);
   import loader_pkg::*;

   logic xfer;

   // One acknowledge slot; a new record waits until it drains
   assign in.ready = ~ack_valid;
   assign xfer     = in.valid && in.ready;

   // Write port B straight from the record
   assign wr_en   = xfer && !in.bad;
   assign wr_addr = in.addr;
   assign wr_data = in.data;

   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         ack_valid <= 1'b0;
      end else if (xfer) begin
         ack_valid <= 1'b1;
      end else if (ack_ready) begin
         ack_valid <= 1'b0;
      end
   end

   // Checksum back to the host, or NAK when a byte was corrupted
   always_ff @(posedge clk_100mhz_buf) begin
      if (xfer) begin
         ack_byte <= in.bad ? `LOADER_NAK : in.check;
      end
   end

endmodule

`default_nettype wire

/* logic/prog_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module prog_mem (
   input  logic                  clk_100mhz_buf,
   input  logic                  wr_en,
   input  loader_pkg::mem_addr_t wr_addr,
   input  loader_pkg::mem_word_t wr_data,
   input  loader_pkg::mem_addr_t rd_addr,
   output loader_pkg::mem_word_t rd_data
);
   import loader_pkg::*;

   mem_word_t mem [`LOADER_MEM_DEPTH];

   // Port B, loader side
   always_ff @(posedge clk_100mhz_buf) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Port A, fetch side, read-before-write on a collision
   always_ff @(posedge clk_100mhz_buf) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

/* logic/record_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One assembled record from the packer to the memory writer
interface record_if;
   import loader_pkg::*;

   logic      valid;
   logic      ready;
   mem_addr_t addr;
   mem_word_t data;
   byte_t     check;
   // Some byte of the record had a framing error
   logic      bad;

   modport src (output valid, output addr, output data, output check, output bad,
                input ready);
   modport dst (input valid, input addr, input data, input check, input bad,
                output ready);

endinterface

`default_nettype wire

/* logic/record_packer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module record_packer (
   input  logic        clk_100mhz_buf,
   input  logic        rst_n,
   byte_stream_if.dst  in,
   record_if.src       out
);
   import loader_pkg::*;

   pack_state_t state;
   logic [3:0]  byte_cnt;
   mem_addr_t   addr_q;
   mem_word_t   data_q;
   byte_t       check_q;
   logic        bad_q;
   logic        take;

   assign in.ready = (state == COLLECT);
   assign take     = in.valid && in.ready;

   assign out.valid = (state == HOLD);
   assign out.addr  = addr_q;
   assign out.data  = data_q;
   assign out.check = check_q;
   assign out.bad   = bad_q;

   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         state    <= COLLECT;
         byte_cnt <= '0;
         check_q  <= '0;
         bad_q    <= 1'b0;
      end else if (state == HOLD) begin
         if (out.ready) begin
            state   <= COLLECT;
            check_q <= '0;
            bad_q   <= 1'b0;
         end
      end else if (take) begin
         check_q <= check_q ^ in.data;
         bad_q   <= bad_q | in.frame_err;
         if (byte_cnt == 4'(`LOADER_REC_BYTES - 1)) begin
            byte_cnt <= '0;
            state    <= HOLD;
         end else begin
            byte_cnt <= byte_cnt + 1'b1;
         end
      end
   end

   // Bytes 0..1 build the address, only the low 14 bits survive
   always_ff @(posedge clk_100mhz_buf) begin
      if (take) begin
         if (byte_cnt < 4'd2) begin
            addr_q <= {addr_q[5:0], in.data};
         end else begin
            data_q <= {data_q[55:0], in.data};
         end
      end
   end

endmodule

`default_nettype wire

/* logic/serial_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_loader_top (
   input  logic        clk_100mhz_buf,
   input  logic        rst_n,
   input  logic        rxd,
   input  logic [1:0]  br_cfg,
   output logic        txd,
   input  logic [13:0] fetch_addr,
   output logic [63:0] fetch_data
);
   import loader_pkg::*;

   logic      wr_en;
   mem_addr_t wr_addr;
   mem_word_t wr_data;
   logic      ack_valid;
   logic      ack_ready;
   byte_t     ack_byte;

   byte_stream_if u_bytes ();
   record_if      u_rec ();

   //////////////////////////////////////////////////////////////////////
   // Receive, pack, write, transmit
   //////////////////////////////////////////////////////////////////////
   uart_rx u_rx (
      .clk_100mhz_buf (clk_100mhz_buf),
      .rst_n          (rst_n),
      .rxd            (rxd),
      .br_cfg         (br_cfg),
      .out            (u_bytes)
   );

   record_packer u_pack (
      .clk_100mhz_buf (clk_100mhz_buf),
      .rst_n          (rst_n),
      .in             (u_bytes),
      .out            (u_rec)
   );

   mem_writer u_wr (
      .clk_100mhz_buf (clk_100mhz_buf),
      .rst_n          (rst_n),
      .in             (u_rec),
      .wr_en          (wr_en),
      .wr_addr        (wr_addr),
      .wr_data        (wr_data),
      .ack_valid      (ack_valid),
      .ack_ready      (ack_ready),
      .ack_byte       (ack_byte)
   );

   uart_tx u_tx (
      .clk_100mhz_buf (clk_100mhz_buf),
      .rst_n          (rst_n),
      .br_cfg         (br_cfg),
      .ack_valid      (ack_valid),
      .ack_ready      (ack_ready),
      .ack_byte       (ack_byte),
      .txd            (txd)
   );

   // Port A left to the processor fetch path
   prog_mem u_mem (
      .clk_100mhz_buf (clk_100mhz_buf),
      .wr_en          (wr_en),
      .wr_addr        (wr_addr),
      .wr_data        (wr_data),
      .rd_addr        (fetch_addr),
      .rd_data        (fetch_data)
   );

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input  logic                  clk_100mhz_buf,
   input  logic                  rst_n,
   input  logic                  rxd,
   input  loader_pkg::baud_cfg_t br_cfg,
   byte_stream_if.src            out
);
   import loader_pkg::*;

   logic       rxd_meta;
   logic       rxd_sync;
   logic       busy;
   logic [3:0] bit_idx;
   bit_div_t   div_cnt;
   bit_div_t   bit_div;
   byte_t      shift;
   logic       sample;
   logic       done;

   assign bit_div = baud_divisor(br_cfg);

   // Mid-bit strobe, bit_idx 0 is the start bit and 9 the stop bit
   assign sample = busy && (div_cnt == '0);
   assign done   = sample && (bit_idx == 4'd9);

   // Line idles high
   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Bit timing
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         bit_idx <= '0;
         div_cnt <= '0;
      end else if (!busy) begin
         // Falling edge, wait half a bit to confirm the start bit
         if (!rxd_sync) begin
            busy    <= 1'b1;
            bit_idx <= '0;
            div_cnt <= bit_div >> 1;
         end
      end else if (div_cnt != '0) begin
         div_cnt <= div_cnt - 1'b1;
      end else begin
         div_cnt <= bit_div - 1'b1;
         if (bit_idx == 4'd0 && rxd_sync) begin
            busy <= 1'b0;   // glitch, not a start bit
         end else if (bit_idx == 4'd9) begin
            busy <= 1'b0;
         end else begin
            bit_idx <= bit_idx + 1'b1;
         end
      end
   end

   // LSB first
   always_ff @(posedge clk_100mhz_buf) begin
      if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
         shift <= {rxd_sync, shift[7:1]};
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Output holding register
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         out.valid <= 1'b0;
      end else if (done) begin
         out.valid <= 1'b1;
      end else if (out.ready) begin
         out.valid <= 1'b0;
      end
   end

   // A newer byte simply replaces one not yet taken
   always_ff @(posedge clk_100mhz_buf) begin
      if (done) begin
         out.data      <= shift;
         out.frame_err <= ~rxd_sync;
      end
   end

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  logic                  clk_100mhz_buf,
   input  logic                  rst_n,
   input  loader_pkg::baud_cfg_t br_cfg,
   input  logic                  ack_valid,
   output logic                  ack_ready,
   input  loader_pkg::byte_t     ack_byte,
   output logic                  txd
);
   import loader_pkg::*;

   logic       busy;
   logic [3:0] bit_cnt;
   bit_div_t   div_cnt;
   bit_div_t   bit_div;
   logic [9:0] frame;
   logic       load;

   assign bit_div   = baud_divisor(br_cfg);
   assign ack_ready = ~busy;
   assign load      = ack_valid && ack_ready;

   //////////////////////////////////////////////////////////////////////
   // Frame sequencing, 10 bits of one divisor each
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         bit_cnt <= '0;
         div_cnt <= '0;
      end else if (load) begin
         busy    <= 1'b1;
         bit_cnt <= '0;
         div_cnt <= bit_div - 1'b1;
      end else if (busy) begin
         if (div_cnt != '0) begin
            div_cnt <= div_cnt - 1'b1;
         end else begin
            div_cnt <= bit_div - 1'b1;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) begin
               busy <= 1'b0;
            end
         end
      end
   end

   // Stop, data LSB first, start
   always_ff @(posedge clk_100mhz_buf) begin
      if (load) begin
         frame <= {1'b1, ack_byte, 1'b0};
      end else if (busy && div_cnt == '0) begin
         frame <= {1'b1, frame[9:1]};
      end
   end

   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         txd <= 1'b1;
      end else begin
         txd <= busy ? frame[0] : 1'b1;
      end
   end

endmodule

`default_nettype wire

/* verif/tb_serial_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module tb_serial_loader;

   // 24 records at 115200 and one at 57600, 11 bytes each on the line
   localparam longint FAST_BITS = 24 * (`LOADER_REC_BYTES + 1) * 12;
   localparam longint SLOW_BITS = (`LOADER_REC_BYTES + 1) * 12;
   localparam longint WATCHDOG_NS = 2 * 10 *
      ((FAST_BITS + 20) * longint'(`LOADER_DIV_115200) +
       SLOW_BITS * longint'(`LOADER_DIV_57600));

   logic        clk_100mhz_buf;
   logic        rst_n;
   logic        rxd;
   logic [1:0]  br_cfg;
   logic        txd;
   logic [13:0] fetch_addr;
   logic [63:0] fetch_data;

   int          bit_cyc;
   int          errors;
   int          checks;
   logic [63:0] ref_mem [logic [13:0]];

   serial_loader_top i_dut (
      .clk_100mhz_buf (clk_100mhz_buf),
      .rst_n          (rst_n),
      .rxd            (rxd),
      .br_cfg         (br_cfg),
      .txd            (txd),
      .fetch_addr     (fetch_addr),
      .fetch_data     (fetch_data)
   );

   initial begin
      clk_100mhz_buf = 1'b0;
      forever #5 clk_100mhz_buf = ~clk_100mhz_buf;
   end

   //////////////////////////////////////////////////////////////////////
   // Host UART model
   //////////////////////////////////////////////////////////////////////
   task automatic send_byte(input logic [7:0] value, input logic stop_level);
      logic [9:0] frame;
      frame = {stop_level, value, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk_100mhz_buf);
         rxd <= frame[i];
         repeat (bit_cyc - 1) @(posedge clk_100mhz_buf);
      end
      // One idle bit between bytes
      @(posedge clk_100mhz_buf);
      rxd <= 1'b1;
      repeat (bit_cyc - 1) @(posedge clk_100mhz_buf);
   endtask

   task automatic recv_byte(output logic [7:0] value, output bit got);
      int waited;
      int limit;
      waited = 0;
      limit  = (`LOADER_REC_BYTES + 2) * 12 * bit_cyc;
      got    = 1'b0;
      value  = '0;
      @(negedge clk_100mhz_buf);
      while (txd !== 1'b0 && waited < limit) begin
         @(negedge clk_100mhz_buf);
         waited++;
      end
      if (txd !== 1'b0) begin
         return;
      end
      // Middle of the start bit, then one bit period per sample
      repeat (bit_cyc / 2) @(negedge clk_100mhz_buf);
      for (int i = 0; i < 8; i++) begin
         repeat (bit_cyc) @(negedge clk_100mhz_buf);
         value[i] = txd;
      end
      repeat (bit_cyc) @(negedge clk_100mhz_buf);
      if (txd !== 1'b1) begin
         $display("Fail txd stop bit: expected 1, got %h", txd);
         errors++;
      end
      got = 1'b1;
   endtask

   // bad_idx picks one byte sent with a low stop bit, -1 for none
   task automatic send_record(input logic [7:0] addr_hi, input logic [7:0] addr_lo,
                              input logic [63:0] word, input int bad_idx);
      logic [7:0]  rec [`LOADER_REC_BYTES];
      logic [7:0]  expected;
      logic [7:0]  ack;
      logic [13:0] addr;
      bit          got;
      addr   = {addr_hi[5:0], addr_lo};
      rec[0] = addr_hi;
      rec[1] = addr_lo;
      for (int i = 0; i < 8; i++) begin
         rec[2 + i] = word[63 - 8 * i -: 8];
      end
      expected = '0;
      for (int i = 0; i < `LOADER_REC_BYTES; i++) begin
         expected = expected ^ rec[i];
      end
      if (bad_idx >= 0) begin
         expected = `LOADER_NAK;
      end
      fork
         begin
            for (int i = 0; i < `LOADER_REC_BYTES; i++) begin
               send_byte(rec[i], (i == bad_idx) ? 1'b0 : 1'b1);
            end
         end
         recv_byte(ack, got);
      join
      checks++;
      if (!got) begin
         $display("No acknowledge byte came back for the record at address %h", addr);
         errors++;
      end else if (ack !== expected) begin
         $display("Fail txd ack at address %h: expected %h, got %h", addr, expected, ack);
         errors++;
      end
      if (bad_idx < 0) begin
         ref_mem[addr] = word;
      end
   endtask

   task automatic readback(input logic [13:0] addr);
      @(posedge clk_100mhz_buf);
      fetch_addr <= addr;
      @(posedge clk_100mhz_buf);
      @(negedge clk_100mhz_buf);
      checks++;
      if (!ref_mem.exists(addr)) begin
         $display("Address %h was never loaded, nothing to compare against", addr);
         errors++;
      end else if (fetch_data !== ref_mem[addr]) begin
         $display("Fail fetch_data at address %h: expected %h, got %h",
                  addr, ref_mem[addr], fetch_data);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////
   task automatic check_idle_line();
      int low_cycles;
      low_cycles = 0;
      repeat (20 * bit_cyc) begin
         @(negedge clk_100mhz_buf);
         if (txd !== 1'b1) begin
            low_cycles++;
         end
      end
      checks++;
      if (low_cycles != 0) begin
         $display("Fail txd while idle: expected 1, got 0 for %0d cycles", low_cycles);
         errors++;
      end
   endtask

   task automatic load_random_records();
      logic [13:0] addr;
      logic [13:0] addrs [$];
      for (int n = 0; n < 20; n++) begin
         do begin
            addr = 14'($urandom);
         end while (ref_mem.exists(addr));
         addrs.push_back(addr);
         // Top two address bits are ignored by the loader
         send_record({2'($urandom), addr[13:8]}, addr[7:0], {$urandom, $urandom}, -1);
      end
      foreach (addrs[i]) begin
         readback(addrs[i]);
      end
   endtask

   task automatic overwrite_same_address();
      send_record(8'h12, 8'h34, 64'h1111_2222_3333_4444, -1);
      send_record(8'h12, 8'h34, 64'h5555_6666_7777_8888, -1);
      readback(14'h1234);
   endtask

   task automatic load_at_57600();
      @(posedge clk_100mhz_buf);
      br_cfg <= 2'b10;
      bit_cyc = int'(`LOADER_DIV_57600);
      send_record(8'hff, 8'hff, 64'hfeed_face_cafe_f00d, -1);
      readback(14'h3fff);
   endtask

   initial begin
      int unsigned seed_ret;
      rxd        = 1'b1;
      br_cfg     = 2'b11;
      fetch_addr = '0;
      rst_n      = 1'b0;
      errors     = 0;
      checks     = 0;
      bit_cyc    = int'(`LOADER_DIV_115200);
      seed_ret   = $urandom(947);
      repeat (8) @(posedge clk_100mhz_buf);
      rst_n <= 1'b1;

      check_idle_line();
      send_record(8'h00, 8'h40, 64'h0123_4567_89ab_cdef, -1);
      readback(14'h0040);
      load_random_records();
      overwrite_same_address();
      // Framing error in a data byte, old word at 0x0040 must survive
      send_record(8'h00, 8'h40, 64'hdead_beef_dead_beef, 5);
      readback(14'h0040);
      load_at_57600();

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog timeout, the tests did not finish in time");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
